// File: build.f
rtl/glb_pkg.sv
rtl/glb_bank_if.sv
rtl/glb_prior_arb.sv
rtl/glb_bank_ram.sv
rtl/glb_bank_xbar.sv
rtl/glb_port_map.sv
rtl/glb_rd_return.sv
rtl/glb_top.sv
dv/glb_tb.sv

// File: dv/glb_tb.sv
// Global buffer testbench
`timescale 1ns/10ps
module glb_tb;
    import glb_pkg::*;

    // DUT ports
    logic                        clk;
    logic                        reset_i;
    bank_flag_t [NUM_PORT-1:0]   cfg_bank_flag_i;
    addr_t      [NUM_WRPORT-1:0] wr_addr_i;
    word_t      [NUM_WRPORT-1:0] wr_dat_i;
    logic       [NUM_WRPORT-1:0] wr_vld_i;
    logic       [NUM_WRPORT-1:0] wr_rdy_o;
    addr_t      [NUM_RDPORT-1:0] rd_addr_i;
    logic       [NUM_RDPORT-1:0] rd_addr_vld_i;
    logic       [NUM_RDPORT-1:0] rd_addr_rdy_o;
    word_t      [NUM_RDPORT-1:0] rd_dat_o;
    logic       [NUM_RDPORT-1:0] rd_dat_vld_o;
    logic       [NUM_RDPORT-1:0] rd_dat_rdy_i;

    // Four words per record, room for 128 records
    logic [31:0] vec [0:511];
    int          n_rec;
    int          cycles = 0;
    int          limit = 100000;
    int          errors = 0;
    int          checks = 0;
    int          stalls = 0;
    int          tests = 0;
    int          test_err = 0;
    int          test_chk = 0;
    logic [31:0] rng;

    glb_top UUT (
        .clk             (clk),
        .reset_i         (reset_i),
        .cfg_bank_flag_i (cfg_bank_flag_i),
        .wr_addr_i       (wr_addr_i),
        .wr_dat_i        (wr_dat_i),
        .wr_vld_i        (wr_vld_i),
        .wr_rdy_o        (wr_rdy_o),
        .rd_addr_i       (rd_addr_i),
        .rd_addr_vld_i   (rd_addr_vld_i),
        .rd_addr_rdy_o   (rd_addr_rdy_o),
        .rd_dat_o        (rd_dat_o),
        .rd_dat_vld_o    (rd_dat_vld_o),
        .rd_dat_rdy_i    (rd_dat_rdy_i)
    );

    // 20 ns clock
    always #10 clk = ~clk;

    // ==============================
    // Run limit
    // ==============================
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, a handshake never completed", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    // Back-pressure source
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset state";
            2:       return "write then read";
            3:       return "address fold";
            4:       return "unallocated and non-owner";
            5:       return "read back-pressure";
            6:       return "read latency";
            default: return "unnamed";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // One line per finished test
    task automatic end_test(input int n);
        $display("test %0d %s: %0d checks, %0d errors", n, test_name(n),
                 checks - test_chk, errors - test_err);
        test_chk = checks;
        test_err = errors;
        tests++;
    endtask

    // ==============================
    // Port drivers
    // ==============================
    task automatic apply_config(input int pg, input bank_flag_t flag);
        @(negedge clk);
        cfg_bank_flag_i[pg] = flag;
    endtask

    task automatic do_write(input int p, input addr_t addr, input word_t data);
        @(negedge clk);
        wr_addr_i[p] = addr;
        wr_dat_i[p]  = data;
        wr_vld_i[p]  = 1'b1;
        // Ready seen here holds up to the next rising edge
        #2;
        while (!wr_rdy_o[p]) begin
            @(negedge clk);
            #2;
        end
        @(negedge clk);
        wr_vld_i[p] = 1'b0;
    endtask

    task automatic do_read(input int r, input addr_t addr, input word_t exp);
        logic  rdy;
        logic  done;
        @(negedge clk);
        rd_addr_i[r]     = addr;
        rd_addr_vld_i[r] = 1'b1;
        #2;
        while (!rd_addr_rdy_o[r]) begin
            @(negedge clk);
            #2;
        end
        // No data before the address is taken
        check_value($sformatf("rd_dat_vld_o[%0d]", r), rd_dat_vld_o[r], 1'b0);
        @(negedge clk);
        rd_addr_vld_i[r] = 1'b0;
        // One cycle after acceptance
        check_value($sformatf("rd_dat_vld_o[%0d]", r), rd_dat_vld_o[r], 1'b1);
        check_value($sformatf("rd_dat_o[%0d]", r), rd_dat_o[r], exp);
        done = 1'b0;
        while (!done) begin
            rng  = xorshift32(rng);
            // Ready one cycle in four
            rdy  = &rng[1:0];
            rd_dat_rdy_i[r] = rdy;
            @(negedge clk);
            if (rdy) begin
                done = 1'b1;
            end else begin
                // Stalled word must not move
                stalls++;
                check_value($sformatf("rd_dat_vld_o[%0d]", r), rd_dat_vld_o[r], 1'b1);
                check_value($sformatf("rd_dat_o[%0d]", r), rd_dat_o[r], exp);
            end
        end
        rd_dat_rdy_i[r] = 1'b0;
        // Consumed, so valid drops
        check_value($sformatf("rd_dat_vld_o[%0d]", r), rd_dat_vld_o[r], 1'b0);
    endtask

    // Request held for n cycles, ready must stay low
    task automatic idle_window(input int pg, input addr_t addr, input int n);
        @(negedge clk);
        if (pg < NUM_WRPORT) begin
            wr_addr_i[pg] = addr;
            wr_vld_i[pg]  = 1'b1;
        end else begin
            rd_addr_i[pg - NUM_WRPORT]     = addr;
            rd_addr_vld_i[pg - NUM_WRPORT] = 1'b1;
        end
        repeat (n) begin
            #2;
            if (pg < NUM_WRPORT) begin
                check_value($sformatf("wr_rdy_o[%0d]", pg), wr_rdy_o[pg], 1'b0);
            end else begin
                check_value($sformatf("rd_addr_rdy_o[%0d]", pg - NUM_WRPORT),
                            rd_addr_rdy_o[pg - NUM_WRPORT], 1'b0);
            end
            @(negedge clk);
        end
        wr_vld_i      = '0;
        rd_addr_vld_i = '0;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk             = 1'b0;
        reset_i         = 1'b1;
        // Every port allocated through reset, so read valids are live
        cfg_bank_flag_i = {4'hc, 4'h3, 4'hc, 4'h3};
        wr_addr_i       = '0;
        wr_dat_i        = '0;
        wr_vld_i        = '0;
        rd_addr_i       = '0;
        rd_addr_vld_i   = '0;
        rd_dat_rdy_i    = '0;
        rng             = 32'hbfb5;

        $readmemh("dv/glb_vectors.txt", vec);
        n_rec = 0;
        while (n_rec < 128 && vec[4*n_rec] !== 32'hf && !$isunknown(vec[4*n_rec])) begin
            n_rec++;
        end
        assert (n_rec < 128 && vec[4*n_rec] === 32'hf) else begin
            $display("Vector file is missing or has no stop record");
            errors++;
        end
        limit = 16 * n_rec + 200;

        // Reset held for 16 cycles
        repeat (16) begin
            @(negedge clk);
            check_value("rd_dat_vld_o", rd_dat_vld_o, '0);
        end
        reset_i = 1'b0;
        @(negedge clk);
        check_value("rd_dat_vld_o", rd_dat_vld_o, '0);
        end_test(1);

        for (int i = 0; i < n_rec; i++) begin
            case (vec[4*i])
                32'h1: apply_config(vec[4*i+1], bank_flag_t'(vec[4*i+3]));
                32'h2: do_write(vec[4*i+1], addr_t'(vec[4*i+2]), vec[4*i+3]);
                32'h3: do_read(vec[4*i+1], addr_t'(vec[4*i+2]), vec[4*i+3]);
                32'h4: idle_window(vec[4*i+1], addr_t'(vec[4*i+2]), vec[4*i+3]);
                32'h5: end_test(vec[4*i+3]);
                default: begin
                    $display("Record %0d has an unknown opcode %h", i, vec[4*i]);
                    errors++;
                end
            endcase
        end

        repeat (2) @(negedge clk);
        $display("Summary: %0d tests, %0d checks, %0d errors, %0d stall cycles",
                 tests, checks, errors, stalls);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: dv/glb_vectors.txt
// Columns: opcode port address data, all hex, one record per line
// 1 config (port 0-3, data = bank flags), 2 write, 3 read (data = expected), 4 idle, 5 end, f stop
// Test 2, two banks per port, writes then reads on each bank
1 0 00 00000003
1 1 00 0000000c
1 2 00 00000003
1 3 00 0000000c
2 0 03 a5a50003
3 0 03 a5a50003
2 0 15 a5a50015
3 0 15 a5a50015
2 1 07 5a5a0107
3 1 07 5a5a0107
2 1 1c 5a5a011c
3 1 1c 5a5a011c
5 0 00 00000002
// Test 3, aliases on a 32 word span
3 0 23 a5a50003
3 0 f5 a5a50015
2 1 47 c0de0047
3 1 07 c0de0047
3 1 e7 c0de0047
// Three banks for port 0, span 48, one bank for port 1
1 0 00 00000007
1 1 00 00000008
1 2 00 00000007
1 3 00 00000008
2 0 40 c0de0140
3 0 10 c0de0140
3 0 70 c0de0140
3 0 27 c0de0047
2 1 3b 0000beef
3 1 0b 0000beef
5 0 00 00000003
// Test 4, write port 1 unallocated, read port 1 shares bank 1 with read port 0
1 0 00 00000003
1 1 00 00000000
1 2 00 00000003
1 3 00 00000002
4 1 05 00000014
4 3 05 00000014
// Write port 1 shares bank 0 with write port 0, read port 1 unallocated
1 1 00 00000001
1 3 00 00000000
4 1 05 00000014
4 3 05 00000014
3 0 15 a5a50015
5 0 00 00000004
// Test 5, reads under random data back-pressure
1 0 00 00000003
1 1 00 0000000c
1 2 00 00000003
1 3 00 0000000c
3 0 03 a5a50003
3 0 15 a5a50015
3 1 07 c0de0047
3 1 1c 5a5a011c
3 0 10 c0de0140
3 1 1b 0000beef
5 0 00 00000005
// Test 6, read right after write
2 0 0a 11110a0a
3 0 0a 11110a0a
2 0 1f 22221f1f
3 0 1f 22221f1f
2 1 3e 33332e2e
3 1 1e 33332e2e
5 0 00 00000006
f 0 00 00000000

// File: rtl/glb_bank_if.sv
// Bank handshake bundle
`timescale 1ns/10ps
interface glb_bank_if;
    import glb_pkg::*;

    // Write channel
    logic      wvalid;
    logic      wready;
    word_idx_t waddr;
    word_t     wdata;

    // Read address channel
    logic      arvalid;
    logic      arready;
    word_idx_t araddr;

    // Read data channel, one word held until taken
    logic      rvalid;
    logic      rready;
    word_t     rdata;

    // Crossbar side drives requests and rready
    modport xbar (
        output wvalid, waddr, wdata,
        output arvalid, araddr, rready,
        input  wready, arready, rvalid, rdata
    );

    // SRAM side answers with readies and read data
    modport bank (
        input  wvalid, waddr, wdata,
        input  arvalid, araddr, rready,
        output wready, arready, rvalid, rdata
    );

endinterface

// File: rtl/glb_bank_ram.sv
// Single port SRAM bank with handshakes
`timescale 1ns/10ps
module glb_bank_ram (
    input  logic     clk,
    input  logic     reset_i,
    glb_bank_if.bank bus
);
    import glb_pkg::*;

    // Storage and output register
    word_t mem [SRAM_WORD];
    word_t rdata_q;

    // Control state
    logic  run_q;
    logic  rvalid_q;

    // Handshake strobes
    logic  wr_acc;
    logic  rd_acc;

    // ==============================
    // Readies
    // ==============================
    // Writes always taken once running
    assign bus.wready  = run_q;
    // Write wins the single port
    // Held word must drain before the next read
    assign bus.arready = run_q & ~bus.wvalid & (~rvalid_q | bus.rready);

    assign wr_acc = bus.wvalid & bus.wready;
    assign rd_acc = bus.arvalid & bus.arready;

    // Read data straight from the output register
    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;

    // ==============================
    // Control
    // ==============================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            run_q    <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            // New read refills, otherwise drain on rready
            if (rd_acc) begin
                rvalid_q <= 1'b1;
            end else if (bus.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // ==============================
    // Array access
    // ==============================
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem[bus.waddr] <= bus.wdata;
        end
        // Word captured one cycle after the address
        if (rd_acc) begin
            rdata_q <= mem[bus.araddr];
        end
    end

    // Stalled read data stays put until the consumer takes it
    rdata_hold: assert property (@(posedge clk) disable iff (reset_i)
        bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));

endmodule

// File: rtl/glb_bank_xbar.sv
// Per bank owner selection and routing
`timescale 1ns/10ps
module glb_bank_xbar #(
    parameter int BANK = 0
) (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  glb_pkg::bank_flag_t [glb_pkg::NUM_PORT-1:0]   cfg_bank_flag_i,
    // Write side, one entry per write port
    input  glb_pkg::bank_flag_t [glb_pkg::NUM_WRPORT-1:0] wr_hit_i,
    input  logic [glb_pkg::NUM_WRPORT-1:0]                wr_vld_i,
    input  glb_pkg::word_idx_t [glb_pkg::NUM_WRPORT-1:0]  wr_word_i,
    input  glb_pkg::word_t [glb_pkg::NUM_WRPORT-1:0]      wr_dat_i,
    // Read side, one entry per read port
    input  glb_pkg::bank_flag_t [glb_pkg::NUM_RDPORT-1:0] rd_hit_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                rd_addr_vld_i,
    input  glb_pkg::word_idx_t [glb_pkg::NUM_RDPORT-1:0]  rd_word_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                rd_dat_rdy_i,
    // Owners of this bank
    output logic [glb_pkg::WR_IDX_W-1:0]                  wr_owner_o,
    output logic [glb_pkg::RD_IDX_W-1:0]                  rd_owner_o,
    // Back to the ports
    output logic [glb_pkg::NUM_WRPORT-1:0]                wready_o,
    output logic [glb_pkg::NUM_RDPORT-1:0]                arready_o,
    output logic                                          rvalid_o,
    output glb_pkg::word_t                                rdata_o,
    glb_bank_if.xbar                                      bus
);
    import glb_pkg::*;

    // This bank's column of the config map
    logic [NUM_WRPORT-1:0] wr_req;
    logic [NUM_RDPORT-1:0] rd_req;
    logic                  wr_found;
    logic                  rd_found;
    // Port that issued the read in flight
    logic [RD_IDX_W-1:0]   rd_owner_q;

    always_comb begin
        for (int p = 0; p < NUM_WRPORT; p++) begin
            wr_req[p] = cfg_bank_flag_i[p][BANK];
        end
        for (int r = 0; r < NUM_RDPORT; r++) begin
            rd_req[r] = cfg_bank_flag_i[NUM_WRPORT + r][BANK];
        end
    end

    // ==============================
    // Ownership
    // ==============================
    glb_prior_arb #(
        .REQ_WIDTH (NUM_WRPORT)
    ) u_wr_arb (
        .req_i   (wr_req),
        .idx_o   (wr_owner_o),
        .found_o (wr_found)
    );

    glb_prior_arb #(
        .REQ_WIDTH (NUM_RDPORT)
    ) u_rd_arb (
        .req_i   (rd_req),
        .idx_o   (rd_owner_o),
        .found_o (rd_found)
    );

    // ==============================
    // Requests into the bank
    // ==============================
    // Owner only, and only when it targets this bank
    assign bus.wvalid  = wr_found & wr_vld_i[wr_owner_o] & wr_hit_i[wr_owner_o][BANK];
    assign bus.waddr   = wr_word_i[wr_owner_o];
    assign bus.wdata   = wr_dat_i[wr_owner_o];
    assign bus.arvalid = rd_found & rd_addr_vld_i[rd_owner_o] & rd_hit_i[rd_owner_o][BANK];
    assign bus.araddr  = rd_word_i[rd_owner_o];

    // Remember who asked
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_owner_q <= '0;
        end else if (bus.arvalid && bus.arready) begin
            rd_owner_q <= rd_owner_o;
        end
    end

    assign bus.rready = rd_dat_rdy_i[rd_owner_q];

    // ==============================
    // Replies to the ports
    // ==============================
    // Readies reach the owner alone
    always_comb begin
        wready_o  = '0;
        arready_o = '0;
        wready_o[wr_owner_o]  = wr_found & bus.wready;
        arready_o[rd_owner_o] = rd_found & bus.arready;
    end

    assign rvalid_o = rd_found & bus.rvalid;
    assign rdata_o  = bus.rdata;

    // Bank writes only come from a port mapped onto it
    wr_from_alloc: assert property (@(posedge clk) disable iff (reset_i)
        bus.wvalid |-> cfg_bank_flag_i[wr_owner_o][BANK]);

endmodule

// File: rtl/glb_pkg.sv
// Global buffer shared definitions
package glb_pkg;

    // ==============================
    // Bank geometry
    // ==============================
    localparam int NUM_BANK   = 4;
    // Must be a power of two
    localparam int SRAM_WORD  = 16;
    localparam int SRAM_WIDTH = 32;
    localparam int ADDR_WIDTH = 8;

    // ==============================
    // Port counts
    // ==============================
    localparam int NUM_WRPORT = 2;
    localparam int NUM_RDPORT = 2;
    // Write ports first, then read ports
    localparam int NUM_PORT   = NUM_WRPORT + NUM_RDPORT;

    // Index widths
    localparam int BANK_IDX_W = $clog2(NUM_BANK);
    localparam int WORD_IDX_W = $clog2(SRAM_WORD);
    localparam int WR_IDX_W   = $clog2(NUM_WRPORT);
    localparam int RD_IDX_W   = $clog2(NUM_RDPORT);

    // ==============================
    // Shared types
    // ==============================
    // One data word
    typedef logic [SRAM_WIDTH-1:0] word_t;
    // Port side address before folding
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [BANK_IDX_W-1:0] bank_idx_t;
    // Word index inside one bank
    typedef logic [WORD_IDX_W-1:0] word_idx_t;
    // One bit per bank, set where the port may go
    typedef logic [NUM_BANK-1:0]   bank_flag_t;

endpackage

// File: rtl/glb_port_map.sv
// Port address to bank and word mapping
`timescale 1ns/10ps
module glb_port_map (
    input  glb_pkg::bank_flag_t          flag_i,
    input  glb_pkg::addr_t               addr_i,
    input  logic [glb_pkg::NUM_BANK-1:0] bank_rdy_i,
    output glb_pkg::bank_idx_t           bank_o,
    output glb_pkg::word_idx_t           word_o,
    output glb_pkg::bank_flag_t          hit_o,
    output logic                         alloc_o,
    output logic                         rdy_o
);
    import glb_pkg::*;

    bank_idx_t                      first_bank;
    // Allocated bank count, up to NUM_BANK
    logic [BANK_IDX_W:0]            n_bank;
    logic [BANK_IDX_W:0]            n_span;
    // Span in words, count times SRAM_WORD
    logic [BANK_IDX_W+WORD_IDX_W:0] span;
    addr_t                          folded;

    // First allocated bank, found also means allocated
    glb_prior_arb #(
        .REQ_WIDTH (NUM_BANK)
    ) u_first_arb (
        .req_i   (flag_i),
        .idx_o   (first_bank),
        .found_o (alloc_o)
    );

    // Count the banks
    always_comb begin
        n_bank = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            n_bank = n_bank + (BANK_IDX_W + 1)'(flag_i[b]);
        end
    end

    // ==============================
    // Address fold
    // ==============================
    // One bank wide when nothing is allocated
    assign n_span = alloc_o ? n_bank : (BANK_IDX_W + 1)'(1);
    assign span   = {n_span, {WORD_IDX_W{1'b0}}};
    assign folded = addr_t'(addr_i % span);

    // Upper bits step from the first bank
    assign bank_o = first_bank + bank_idx_t'(folded >> WORD_IDX_W);
    assign word_o = folded[WORD_IDX_W-1:0];

    // One hot target, empty when unallocated
    always_comb begin
        hit_o         = '0;
        hit_o[bank_o] = alloc_o;
    end

    // Ready of the target bank for this port
    assign rdy_o = alloc_o & bank_rdy_i[bank_o];

endmodule

// File: rtl/glb_prior_arb.sv
// Lowest index priority arbiter
`timescale 1ns/10ps
module glb_prior_arb #(
    parameter int REQ_WIDTH = 4
) (
    input  logic [REQ_WIDTH-1:0]         req_i,
    output logic [$clog2(REQ_WIDTH)-1:0] idx_o,
    output logic                         found_o
);

    // Scan from the top so the lowest set bit wins last
    always_comb begin
        idx_o   = '0;
        found_o = 1'b0;
        for (int i = REQ_WIDTH - 1; i >= 0; i--) begin
            if (req_i[i]) begin
                idx_o   = i[$clog2(REQ_WIDTH)-1:0];
                found_o = 1'b1;
            end
        end
    end

    // Winner is set and nothing below it is set
    always_comb begin
        if (found_o) begin
            winner_low: assert #0 (req_i[idx_o] &&
                ((req_i & ~({REQ_WIDTH{1'b1}} << idx_o)) == '0));
        end
    end

endmodule

// File: rtl/glb_rd_return.sv
// Read port data return
`timescale 1ns/10ps
module glb_rd_return (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   map_rdy_i,
    input  logic                                   alloc_i,
    input  glb_pkg::bank_idx_t                     bank_i,
    input  logic                                   addr_vld_i,
    input  logic [glb_pkg::NUM_BANK-1:0]           bank_rvalid_i,
    input  glb_pkg::word_t [glb_pkg::NUM_BANK-1:0] bank_rdata_i,
    input  logic                                   dat_rdy_i,
    output logic                                   addr_rdy_o,
    output glb_pkg::word_t                         dat_o,
    output logic                                   dat_vld_o
);
    import glb_pkg::*;

    // One read in flight
    logic      pend_q;
    // Bank serving it
    bank_idx_t bank_q;
    logic      addr_acc;
    logic      dat_acc;

    // ==============================
    // Data side
    // ==============================
    assign dat_vld_o = alloc_i & pend_q & bank_rvalid_i[bank_q];
    assign dat_o     = bank_rdata_i[bank_q];
    assign dat_acc   = dat_vld_o & dat_rdy_i;

    // Next address only when the held word leaves this cycle
    assign addr_rdy_o = alloc_i & map_rdy_i & (~pend_q | dat_acc);
    assign addr_acc   = addr_vld_i & addr_rdy_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pend_q <= 1'b0;
        end else if (addr_acc) begin
            pend_q <= 1'b1;
        end else if (dat_acc) begin
            pend_q <= 1'b0;
        end
    end

    // Latched with the address
    always_ff @(posedge clk) begin
        if (addr_acc) begin
            bank_q <= bank_i;
        end
    end

    // Valid edge follows an accepted address by one cycle
    vld_after_addr: assert property (@(posedge clk) disable iff (reset_i)
        $rose(dat_vld_o) |-> $past(addr_vld_i && addr_rdy_o));

endmodule

// File: rtl/glb_top.sv
// Banked global buffer top
`timescale 1ns/10ps
module glb_top (
    input  logic                                            clk,
    input  logic                                            reset_i,
    input  glb_pkg::bank_flag_t [glb_pkg::NUM_PORT-1:0]     cfg_bank_flag_i,
    // Write ports
    input  glb_pkg::addr_t [glb_pkg::NUM_WRPORT-1:0]        wr_addr_i,
    input  glb_pkg::word_t [glb_pkg::NUM_WRPORT-1:0]        wr_dat_i,
    input  logic [glb_pkg::NUM_WRPORT-1:0]                  wr_vld_i,
    output logic [glb_pkg::NUM_WRPORT-1:0]                  wr_rdy_o,
    // Read ports
    input  glb_pkg::addr_t [glb_pkg::NUM_RDPORT-1:0]        rd_addr_i,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                  rd_addr_vld_i,
    output logic [glb_pkg::NUM_RDPORT-1:0]                  rd_addr_rdy_o,
    output glb_pkg::word_t [glb_pkg::NUM_RDPORT-1:0]        rd_dat_o,
    output logic [glb_pkg::NUM_RDPORT-1:0]                  rd_dat_vld_o,
    input  logic [glb_pkg::NUM_RDPORT-1:0]                  rd_dat_rdy_i
);
    import glb_pkg::*;

    // Write port mapping
    bank_flag_t [NUM_WRPORT-1:0]            wr_hit;
    word_idx_t  [NUM_WRPORT-1:0]            wr_word;
    bank_flag_t [NUM_WRPORT-1:0]            wr_bank_rdy;

    // Read port mapping
    bank_flag_t [NUM_RDPORT-1:0]            rd_hit;
    word_idx_t  [NUM_RDPORT-1:0]            rd_word;
    bank_idx_t  [NUM_RDPORT-1:0]            rd_bank;
    bank_flag_t [NUM_RDPORT-1:0]            rd_bank_rdy;
    logic       [NUM_RDPORT-1:0]            rd_alloc;
    logic       [NUM_RDPORT-1:0]            rd_map_rdy;
    // Address handshakes that complete at the port
    logic       [NUM_RDPORT-1:0]            rd_fire;

    // Per bank replies
    logic [NUM_BANK-1:0][NUM_WRPORT-1:0]    bank_wready;
    logic [NUM_BANK-1:0][NUM_RDPORT-1:0]    bank_arready;
    logic [NUM_BANK-1:0]                    bank_rvalid;
    word_t [NUM_BANK-1:0]                   bank_rdata;

    assign rd_fire = rd_addr_vld_i & rd_addr_rdy_o;

    // ==============================
    // Write ports
    // ==============================
    for (genvar p = 0; p < NUM_WRPORT; p++) begin : g_wr
        for (genvar b = 0; b < NUM_BANK; b++) begin : g_rdy
            assign wr_bank_rdy[p][b] = bank_wready[b][p];
        end

        // Ready only through a bank this port owns
        glb_port_map u_map (
            .flag_i     (cfg_bank_flag_i[p]),
            .addr_i     (wr_addr_i[p]),
            .bank_rdy_i (wr_bank_rdy[p]),
            .bank_o     (),
            .word_o     (wr_word[p]),
            .hit_o      (wr_hit[p]),
            .alloc_o    (),
            .rdy_o      (wr_rdy_o[p])
        );
    end

    // ==============================
    // Read ports
    // ==============================
    for (genvar r = 0; r < NUM_RDPORT; r++) begin : g_rd
        for (genvar b = 0; b < NUM_BANK; b++) begin : g_rdy
            assign rd_bank_rdy[r][b] = bank_arready[b][r];
        end

        glb_port_map u_map (
            .flag_i     (cfg_bank_flag_i[NUM_WRPORT + r]),
            .addr_i     (rd_addr_i[r]),
            .bank_rdy_i (rd_bank_rdy[r]),
            .bank_o     (rd_bank[r]),
            .word_o     (rd_word[r]),
            .hit_o      (rd_hit[r]),
            .alloc_o    (rd_alloc[r]),
            .rdy_o      (rd_map_rdy[r])
        );

        glb_rd_return u_ret (
            .clk           (clk),
            .reset_i       (reset_i),
            .map_rdy_i     (rd_map_rdy[r]),
            .alloc_i       (rd_alloc[r]),
            .bank_i        (rd_bank[r]),
            .addr_vld_i    (rd_addr_vld_i[r]),
            .bank_rvalid_i (bank_rvalid),
            .bank_rdata_i  (bank_rdata),
            .dat_rdy_i     (rd_dat_rdy_i[r]),
            .addr_rdy_o    (rd_addr_rdy_o[r]),
            .dat_o         (rd_dat_o[r]),
            .dat_vld_o     (rd_dat_vld_o[r])
        );
    end

    // ==============================
    // Banks
    // ==============================
    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        glb_bank_if u_bus ();

        // Owner outputs left open here
        glb_bank_xbar #(
            .BANK (b)
        ) u_xbar (
            .clk             (clk),
            .reset_i         (reset_i),
            .cfg_bank_flag_i (cfg_bank_flag_i),
            .wr_hit_i        (wr_hit),
            .wr_vld_i        (wr_vld_i),
            .wr_word_i       (wr_word),
            .wr_dat_i        (wr_dat_i),
            .rd_hit_i        (rd_hit),
            .rd_addr_vld_i   (rd_fire),
            .rd_word_i       (rd_word),
            .rd_dat_rdy_i    (rd_dat_rdy_i),
            .wr_owner_o      (),
            .rd_owner_o      (),
            .wready_o        (bank_wready[b]),
            .arready_o       (bank_arready[b]),
            .rvalid_o        (bank_rvalid[b]),
            .rdata_o         (bank_rdata[b]),
            .bus             (u_bus)
        );

        glb_bank_ram u_ram (
            .clk     (clk),
            .reset_i (reset_i),
            .bus     (u_bus)
        );
    end

endmodule
